//--- Bender.yml
package:
  name: buf_mgr

sources:
  - files:
      - buf_cfg_pkg.sv
      - buf_ctrl_pkg.sv
      - free_list_ram_fifo.sv
      - prefetch_fifo.sv
      - freeb_ctrl.sv
      - buf_link_table.sv
      - buf_mgr_top.sv
  - target: simulation
    files:
      - tb_buf_mgr.sv

//--- buf_cfg_pkg.sv
// Sizing defaults for the buffer manager; the top level takes these as parameter defaults
package buf_cfg_pkg;

    // Width of a buffer pointer, giving 2^8 buffers
    parameter int BPTR_NBITS_DEF = 8;

    // Width of an input port identifier
    parameter int ID_NBITS_DEF = 2;

    // Number of input ports tracked for link building
    // Must not exceed 2^ID_NBITS_DEF
    parameter int NUM_PORTS_DEF = 4;

endpackage

//--- buf_ctrl_pkg.sv
// Control encodings shared by the free-buffer controller, its prefetch queue and the testbench
package buf_ctrl_pkg;

    // Free-list initialisation sequencer
    // init_idle    entered after reset or on a re-init request
    // reset_freeb  both FIFOs held in reset for one cycle
    // init_freeb   one pointer written per cycle, ascending
    // init_done    free list ready, normal operation
    typedef enum logic [1:0] {
        init_idle   = 2'd0,
        reset_freeb = 2'd1,
        init_freeb  = 2'd2,
        init_done   = 2'd3
    } init_state_t;

    // Entries in the prefetch queue in front of the free-list RAM
    parameter int PREFETCH_DEPTH = 2;

endpackage

//--- buf_link_table.sv
// Next-buffer table written from link events, read by downstream packet readers
`timescale 1ns/1ps

module buf_link_table #(
    parameter int BPTR_NBITS = buf_cfg_pkg::BPTR_NBITS_DEF
) (
    input  logic                  clk,
    input  logic                  link_valid,
    input  logic [BPTR_NBITS-1:0] link_prev,
    input  logic [BPTR_NBITS-1:0] link_cur,
    input  logic [BPTR_NBITS-1:0] link_rd_ptr,
    output logic [BPTR_NBITS-1:0] link_rd_next
);

    localparam int NUM_BUFS = 1 << BPTR_NBITS;

    // One entry per buffer, holding the buffer that follows it
    logic [BPTR_NBITS-1:0] next_buf [NUM_BUFS];

    // A link event points the previous buffer at the current one
    always_ff @(posedge clk) begin
        if (link_valid) begin
            next_buf[link_prev] <= link_cur;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        link_rd_next <= next_buf[link_rd_ptr];
    end

endmodule

//--- buf_mgr_top.sv
// Buffer manager top level: free-buffer control plus the link table, sized by its parameters
`timescale 1ns/1ps

module buf_mgr_top #(
    parameter int BPTR_NBITS = buf_cfg_pkg::BPTR_NBITS_DEF,
    parameter int ID_NBITS   = buf_cfg_pkg::ID_NBITS_DEF,
    parameter int NUM_PORTS  = buf_cfg_pkg::NUM_PORTS_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  freeb_init,
    input  logic                  free_buf_req,
    input  logic                  rel_buf_valid,
    input  logic [BPTR_NBITS-1:0] rel_buf_ptr,
    input  logic                  write_data_valid,
    input  logic [BPTR_NBITS-1:0] write_buf_ptr,
    input  logic                  write_sop,
    input  logic [ID_NBITS-1:0]   write_port_id,
    input  logic [BPTR_NBITS-1:0] link_rd_ptr,
    output logic                  freeb_init_done,
    output logic                  free_buf_valid,
    output logic                  free_buf_available,
    output logic [BPTR_NBITS-1:0] free_buf_ptr,
    output logic                  inc_freeb_rd_count,
    output logic                  inc_freeb_wr_count,
    output logic [BPTR_NBITS-1:0] link_rd_next
);

    logic                  link_valid;
    logic [BPTR_NBITS-1:0] link_prev;
    logic [BPTR_NBITS-1:0] link_cur;

    freeb_ctrl #(
        .BPTR_NBITS(BPTR_NBITS),
        .ID_NBITS  (ID_NBITS),
        .NUM_PORTS (NUM_PORTS)
    ) freeb_ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .freeb_init        (freeb_init),
        .rel_buf_valid     (rel_buf_valid),
        .free_buf_req      (free_buf_req),
        .write_data_valid  (write_data_valid),
        .write_sop         (write_sop),
        .rel_buf_ptr       (rel_buf_ptr),
        .write_buf_ptr     (write_buf_ptr),
        .write_port_id     (write_port_id),
        .freeb_init_done   (freeb_init_done),
        .inc_freeb_rd_count(inc_freeb_rd_count),
        .inc_freeb_wr_count(inc_freeb_wr_count),
        .free_buf_valid    (free_buf_valid),
        .free_buf_available(free_buf_available),
        .link_valid        (link_valid),
        .free_buf_ptr      (free_buf_ptr),
        .link_prev         (link_prev),
        .link_cur          (link_cur)
    );

    buf_link_table #(
        .BPTR_NBITS(BPTR_NBITS)
    ) link_table_i (
        .clk         (clk),
        .link_valid  (link_valid),
        .link_prev   (link_prev),
        .link_cur    (link_cur),
        .link_rd_ptr (link_rd_ptr),
        .link_rd_next(link_rd_next)
    );

endmodule

//--- flist.f
buf_cfg_pkg.sv
buf_ctrl_pkg.sv
free_list_ram_fifo.sv
prefetch_fifo.sv
freeb_ctrl.sv
buf_link_table.sv
buf_mgr_top.sv
tb_buf_mgr.sv

//--- free_list_ram_fifo.sv
// RAM-backed FIFO of free buffer pointers; read data is registered and its write pointer is visible
`timescale 1ns/1ps

module free_list_ram_fifo #(
    parameter int W = buf_cfg_pkg::BPTR_NBITS_DEF,
    parameter int D = buf_cfg_pkg::BPTR_NBITS_DEF
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [W-1:0] din,
    input  logic         wr,
    input  logic         rd,
    output logic [W-1:0] dout,
    output logic [D-1:0] wptr,
    output logic [D:0]   count,
    output logic         empty,
    output logic         full
);

    localparam int DEPTH = 1 << D;

    logic [W-1:0] mem [DEPTH];
    logic [D-1:0] rptr;
    logic         wr_en;
    logic         rd_en;

    // A read frees a slot, so a write into a full FIFO is allowed in the same cycle
    assign rd_en = rd & ~empty;
    assign wr_en = wr & (~full | rd_en);

    assign empty = (count == '0);
    assign full  = count[D];

    // Storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr] <= din;
        end
        if (rd_en) begin
            dout <= mem[rptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1;
            end
            if (rd_en) begin
                rptr <= rptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- freeb_ctrl.sv
// Free-buffer control: fills the free list, hands out and takes back pointers, emits link events
`timescale 1ns/1ps

module freeb_ctrl #(
    parameter int BPTR_NBITS = buf_cfg_pkg::BPTR_NBITS_DEF,
    parameter int ID_NBITS   = buf_cfg_pkg::ID_NBITS_DEF,
    parameter int NUM_PORTS  = buf_cfg_pkg::NUM_PORTS_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  freeb_init,
    input  logic                  rel_buf_valid,
    input  logic                  free_buf_req,
    input  logic                  write_data_valid,
    input  logic                  write_sop,
    input  logic [BPTR_NBITS-1:0] rel_buf_ptr,
    input  logic [BPTR_NBITS-1:0] write_buf_ptr,
    input  logic [ID_NBITS-1:0]   write_port_id,
    output logic                  freeb_init_done,
    output logic                  inc_freeb_rd_count,
    output logic                  inc_freeb_wr_count,
    output logic                  free_buf_valid,
    output logic                  free_buf_available,
    output logic                  link_valid,
    output logic [BPTR_NBITS-1:0] free_buf_ptr,
    output logic [BPTR_NBITS-1:0] link_prev,
    output logic [BPTR_NBITS-1:0] link_cur
);

    localparam int PF_DBITS = $clog2(buf_ctrl_pkg::PREFETCH_DEPTH);

    buf_ctrl_pkg::init_state_t init_st;
    buf_ctrl_pkg::init_state_t nxt_init_st;

    logic                  fifo_rst_n;
    logic                  freeb_init_wr;
    logic                  free_buf_req_d1;
    logic                  rel_buf_valid_d1;
    logic [BPTR_NBITS-1:0] rel_buf_ptr_d1;
    logic                  write_data_valid_d1;
    logic                  write_sop_d1;
    logic [BPTR_NBITS-1:0] write_buf_ptr_d1;
    logic [ID_NBITS-1:0]   write_port_id_d1;
    logic [BPTR_NBITS-1:0] last_buf [NUM_PORTS];

    logic                  fifo_rd;
    logic                  fifo_wr;
    logic                  fifo_rd_d1;
    logic [BPTR_NBITS-1:0] fifo_din;
    logic [BPTR_NBITS-1:0] fifo_dout;
    logic [BPTR_NBITS-1:0] fifo_wptr;
    logic                  fifo_empty;
    logic                  fifo_full;

    logic                  pf_rd;
    logic                  pf_wr;
    logic [BPTR_NBITS-1:0] pf_dout;
    logic                  pf_empty;
    logic                  pf_full;
    logic                  pf_fullm1;

    // Init sequencer
    always_comb begin
        nxt_init_st = init_st;
        case (init_st)
            buf_ctrl_pkg::init_idle:   nxt_init_st = buf_ctrl_pkg::reset_freeb;
            buf_ctrl_pkg::reset_freeb: nxt_init_st = buf_ctrl_pkg::init_freeb;
            buf_ctrl_pkg::init_freeb: begin
                // Last pointer goes in on the way out of this state
                if (&fifo_wptr) begin
                    nxt_init_st = buf_ctrl_pkg::init_done;
                end
            end
            buf_ctrl_pkg::init_done: begin
                if (freeb_init) begin
                    nxt_init_st = buf_ctrl_pkg::init_idle;
                end
            end
            default: nxt_init_st = buf_ctrl_pkg::init_idle;
        endcase
    end

    // Sequencer writes take priority over released pointers
    assign fifo_wr  = freeb_init_wr | (rel_buf_valid_d1 & ~fifo_full);
    assign fifo_din = freeb_init_wr ? fifo_wptr : rel_buf_ptr_d1;

    // Refill the prefetch queue, counting a read still on its way out of the RAM
    assign pf_wr   = fifo_rd_d1;
    assign fifo_rd = (init_st == buf_ctrl_pkg::init_done) & ~fifo_empty
                   & ~(pf_full | (pf_wr & pf_fullm1));

    // Request dispensed from the queue head one cycle after it arrives
    assign pf_rd = free_buf_req_d1 & freeb_init_done & ~pf_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_st             <= buf_ctrl_pkg::init_idle;
            fifo_rst_n          <= 1'b0;
            freeb_init_wr       <= 1'b0;
            freeb_init_done     <= 1'b0;
            free_buf_req_d1     <= 1'b0;
            rel_buf_valid_d1    <= 1'b0;
            write_data_valid_d1 <= 1'b0;
            fifo_rd_d1          <= 1'b0;
            free_buf_valid      <= 1'b0;
            free_buf_available  <= 1'b0;
            inc_freeb_rd_count  <= 1'b0;
            inc_freeb_wr_count  <= 1'b0;
            link_valid          <= 1'b0;
        end else begin
            init_st             <= nxt_init_st;
            fifo_rst_n          <= (nxt_init_st != buf_ctrl_pkg::reset_freeb);
            freeb_init_wr       <= (nxt_init_st == buf_ctrl_pkg::init_freeb);
            freeb_init_done     <= (init_st == buf_ctrl_pkg::init_done);
            free_buf_req_d1     <= free_buf_req;
            rel_buf_valid_d1    <= rel_buf_valid;
            write_data_valid_d1 <= write_data_valid;
            fifo_rd_d1          <= fifo_rd;
            free_buf_valid      <= free_buf_req_d1;
            free_buf_available  <= pf_rd;
            inc_freeb_rd_count  <= pf_rd;
            inc_freeb_wr_count  <= fifo_wr;
            // Only continuation writes link two buffers
            link_valid          <= write_data_valid_d1 & ~write_sop_d1;
        end
    end

    // Payload stages and per-port last written buffer
    always_ff @(posedge clk) begin
        rel_buf_ptr_d1   <= rel_buf_ptr;
        write_buf_ptr_d1 <= write_buf_ptr;
        write_port_id_d1 <= write_port_id;
        write_sop_d1     <= write_sop;
        free_buf_ptr     <= pf_dout;
        link_prev        <= last_buf[write_port_id_d1];
        link_cur         <= write_buf_ptr_d1;
        if (write_data_valid_d1) begin
            last_buf[write_port_id_d1] <= write_buf_ptr_d1;
        end
    end

    free_list_ram_fifo #(
        .W(BPTR_NBITS),
        .D(BPTR_NBITS)
    ) free_list_i (
        .clk  (clk),
        .rst_n(fifo_rst_n),
        .din  (fifo_din),
        .wr   (fifo_wr),
        .rd   (fifo_rd),
        .dout (fifo_dout),
        .wptr (fifo_wptr),
        .count(),
        .empty(fifo_empty),
        .full (fifo_full)
    );

    prefetch_fifo #(
        .W(BPTR_NBITS),
        .D(PF_DBITS)
    ) prefetch_i (
        .clk   (clk),
        .rst_n (fifo_rst_n),
        .din   (fifo_dout),
        .wr    (pf_wr),
        .rd    (pf_rd),
        .dout  (pf_dout),
        .count (),
        .empty (pf_empty),
        .full  (pf_full),
        .fullm1(pf_fullm1)
    );

endmodule

//--- prefetch_fifo.sv
// Shallow flop FIFO that holds prefetched free pointers and shows its head without a read delay
`timescale 1ns/1ps

module prefetch_fifo #(
    parameter int W = buf_cfg_pkg::BPTR_NBITS_DEF,
    parameter int D = $clog2(buf_ctrl_pkg::PREFETCH_DEPTH)
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [W-1:0] din,
    input  logic         wr,
    input  logic         rd,
    output logic [W-1:0] dout,
    output logic [2:0]   count,
    output logic         empty,
    output logic         full,
    output logic         fullm1
);

    localparam int DEPTH = 1 << D;

    logic [W-1:0] mem [DEPTH];
    logic [D-1:0] wr_idx;
    logic [D-1:0] rd_idx;
    logic         wr_en;
    logic         rd_en;

    assign wr_en = wr & ~full;
    assign rd_en = rd & ~empty;

    // Head of queue straight from the flops
    assign dout = mem[rd_idx];

    assign empty  = (count == 3'd0);
    assign full   = (count == 3'(DEPTH));
    assign fullm1 = (count == 3'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (rd_en) begin
                rd_idx <= rd_idx + 1'b1;
            end
            count <= count + 3'(wr_en) - 3'(rd_en);
        end
    end

endmodule

//--- tb_buf_mgr.sv
// Table-driven testbench for the buffer manager; run tb_buf_mgr with the sources from flist.f
`timescale 1ns/1ps

module tb_buf_mgr;

    localparam int bptr_nbits = 4;
    localparam int num_bufs = 1 << bptr_nbits;
    localparam int num_ports = 4;
    localparam int max_rows = 96;
    localparam int gap_cycles = 4;
    localparam int resp_timeout = 8;
    localparam int init_timeout = 64;
    localparam int op_req = 0;
    localparam int op_rel = 1;
    localparam int op_wr = 2;
    localparam int op_init = 3;
    localparam int op_link = 4;

    logic clk, rst_n, freeb_init, free_buf_req, rel_buf_valid;
    logic write_data_valid, write_sop;
    logic [bptr_nbits-1:0] rel_buf_ptr, write_buf_ptr, link_rd_ptr;
    logic [1:0] write_port_id;
    logic freeb_init_done, free_buf_valid, free_buf_available;
    logic inc_freeb_rd_count, inc_freeb_wr_count;
    logic [bptr_nbits-1:0] free_buf_ptr, link_rd_next;

    // Stimulus table with expected values
    int row_test [max_rows];
    int row_op [max_rows];
    int row_arg [max_rows];
    int row_sop [max_rows];
    int row_port [max_rows];
    int row_exp_avail [max_rows];
    int row_exp_val [max_rows];
    int num_rows = 0;

    // Reference model of the free list and the per-port links
    int free_q [$];
    int last_buf_m [num_ports];
    int exp_next [num_bufs];
    int exp_rd [1:5];
    int exp_wr [1:5];
    string test_name [1:5];

    int rd_pulses = 0;
    int wr_pulses = 0;
    int rd_base, wr_base, errors, test_errs, rows_done, cur_test;
    bit timed_out = 1'b0;
    logic [15:0] lfsr_state = 16'd63450;

    buf_mgr_top #(
        .BPTR_NBITS(bptr_nbits),
        .ID_NBITS  (2),
        .NUM_PORTS (num_ports)
    ) dut_i (
        .clk(clk), .rst_n(rst_n), .freeb_init(freeb_init), .free_buf_req(free_buf_req),
        .rel_buf_valid(rel_buf_valid), .rel_buf_ptr(rel_buf_ptr),
        .write_data_valid(write_data_valid), .write_buf_ptr(write_buf_ptr),
        .write_sop(write_sop), .write_port_id(write_port_id), .link_rd_ptr(link_rd_ptr),
        .freeb_init_done(freeb_init_done), .free_buf_valid(free_buf_valid),
        .free_buf_available(free_buf_available), .free_buf_ptr(free_buf_ptr),
        .inc_freeb_rd_count(inc_freeb_rd_count), .inc_freeb_wr_count(inc_freeb_wr_count),
        .link_rd_next(link_rd_next)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Counter pulses are one cycle wide, so one sample per cycle counts each once
    always @(negedge clk) begin
        if (inc_freeb_rd_count === 1'b1) rd_pulses++;
        if (inc_freeb_wr_count === 1'b1) wr_pulses++;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic log_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic note_timeout(input string what);
        buf_ctrl_pkg::init_state_t st;
        st = dut_i.freeb_ctrl_i.init_st;
        $display("Timeout while waiting for %s at %0t, sequencer in %s", what, $time, st.name());
        timed_out = 1'b1;
        errors++;
        test_errs++;
    endtask

    task automatic refill_model();
        free_q.delete();
        for (int i = 0; i < num_bufs; i++) free_q.push_back(i);
    endtask

    task automatic add_row(input int test, input int op, input int arg, input int sop,
                           input int port);
        row_test[num_rows] = test;
        row_op[num_rows] = op;
        row_arg[num_rows] = arg;
        row_sop[num_rows] = sop;
        row_port[num_rows] = port;
        row_exp_avail[num_rows] = 0;
        row_exp_val[num_rows] = 0;
        case (op)
            op_req: begin
                if (free_q.size() > 0) begin
                    row_exp_avail[num_rows] = 1;
                    row_exp_val[num_rows] = free_q.pop_front();
                    exp_rd[test]++;
                end
            end
            op_rel: begin
                free_q.push_back(arg);
                exp_wr[test]++;
            end
            op_wr: begin
                // A continuation links the port's previous buffer to this one
                if (sop == 0) exp_next[last_buf_m[port]] = arg;
                last_buf_m[port] = arg;
            end
            op_init: begin
                refill_model();
                exp_wr[test] += num_bufs;
            end
            default: row_exp_val[num_rows] = exp_next[arg];
        endcase
        num_rows++;
    endtask

    task automatic build_table();
        int perm [num_bufs];
        int wr_port [13];
        int wr_buf [13];
        int wr_sop [13];
        int rd_list [7];
        int r, j, t;
        test_name[1] = "initial fill";
        test_name[2] = "exhaustion";
        test_name[3] = "release and reuse";
        test_name[4] = "link building";
        test_name[5] = "re-initialisation";
        for (int k = 1; k <= 5; k++) begin
            exp_rd[k] = 0;
            exp_wr[k] = 0;
        end
        refill_model();
        for (int i = 0; i < num_bufs; i++) add_row(1, op_req, 0, 0, 0);
        add_row(2, op_req, 0, 0, 0);
        // Release order is a shuffle of all pointers
        for (int i = 0; i < num_bufs; i++) perm[i] = i;
        for (int i = num_bufs - 1; i > 0; i--) begin
            draw_bits(4, r);
            j = r % (i + 1);
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        for (int i = 0; i < num_bufs; i++) add_row(3, op_rel, perm[i], 0, 0);
        for (int i = 0; i < num_bufs; i++) add_row(3, op_req, 0, 0, 0);
        // Interleaved packets on four ports, port 3 ends on a linked buffer before a new packet
        wr_port = '{0, 1, 0, 2, 1, 0, 2, 3, 1, 3, 2, 3, 3};
        wr_buf = '{3, 10, 5, 0, 14, 8, 6, 1, 2, 11, 13, 0, 9};
        wr_sop = '{1, 1, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 1};
        rd_list = '{3, 5, 10, 14, 0, 6, 1};
        for (int i = 0; i < 13; i++) add_row(4, op_wr, wr_buf[i], wr_sop[i], wr_port[i]);
        for (int i = 0; i < 7; i++) add_row(4, op_link, rd_list[i], 0, 0);
        // A few pointers sit in the free list and prefetch queue when the re-init hits
        for (int i = 0; i < 3; i++) add_row(5, op_rel, perm[i], 0, 0);
        add_row(5, op_init, 0, 0, 0);
        for (int i = 0; i < num_bufs; i++) add_row(5, op_req, 0, 0, 0);
    endtask

    task automatic wait_init_level(input logic level, input int limit, input string what);
        int k;
        k = 0;
        do begin
            @(negedge clk);
            k++;
        end while (freeb_init_done !== level && k < limit);
        if (freeb_init_done !== level) note_timeout(what);
    endtask

    // Waits for a one-cycle strobe and returns the cycles since the request cycle
    task automatic wait_strobe(input bit use_wr, output int k, output bit got);
        k = 0;
        got = 1'b0;
        while (!got && k < resp_timeout) begin
            @(negedge clk);
            k++;
            got = use_wr ? (inc_freeb_wr_count === 1'b1) : (free_buf_valid === 1'b1);
        end
    endtask

    task automatic apply_row(input int i);
        int k;
        bit got;
        @(posedge clk);
        case (row_op[i])
            op_req: begin
                free_buf_req <= 1'b1;
                @(posedge clk);
                free_buf_req <= 1'b0;
                wait_strobe(1'b0, k, got);
                if (!got) begin
                    note_timeout("free_buf_valid after a request");
                end else begin
                    if (k != 2) log_fail($sformatf("row %0d: free_buf_valid after %0d cycles", i, k));
                    if (free_buf_available !== 1'(row_exp_avail[i]))
                        log_fail($sformatf("row %0d: free_buf_available %b, expected %0d",
                                           i, free_buf_available, row_exp_avail[i]));
                    if (row_exp_avail[i] != 0 && free_buf_ptr !== bptr_nbits'(row_exp_val[i]))
                        log_fail($sformatf("row %0d: free_buf_ptr %0d, expected %0d",
                                           i, free_buf_ptr, row_exp_val[i]));
                    if (inc_freeb_rd_count !== 1'(row_exp_avail[i]))
                        log_fail($sformatf("row %0d: inc_freeb_rd_count %b",
                                           i, inc_freeb_rd_count));
                end
            end
            op_rel: begin
                rel_buf_valid <= 1'b1;
                rel_buf_ptr <= bptr_nbits'(row_arg[i]);
                @(posedge clk);
                rel_buf_valid <= 1'b0;
                wait_strobe(1'b1, k, got);
                if (!got) note_timeout("inc_freeb_wr_count after a release");
                else if (k != 2)
                    log_fail($sformatf("row %0d: release enqueued after %0d cycles", i, k));
            end
            op_wr: begin
                write_data_valid <= 1'b1;
                write_buf_ptr <= bptr_nbits'(row_arg[i]);
                write_sop <= 1'(row_sop[i]);
                write_port_id <= 2'(row_port[i]);
                @(posedge clk);
                write_data_valid <= 1'b0;
            end
            op_init: begin
                freeb_init <= 1'b1;
                @(posedge clk);
                freeb_init <= 1'b0;
                wait_init_level(1'b0, resp_timeout, "freeb_init_done to drop");
                if (!timed_out) wait_init_level(1'b1, init_timeout, "freeb_init_done to rise again");
            end
            default: begin
                link_rd_ptr <= bptr_nbits'(row_arg[i]);
                @(posedge clk);
                @(negedge clk);
                if (link_rd_next !== bptr_nbits'(row_exp_val[i]))
                    log_fail($sformatf("row %0d: next of buffer %0d is %0d, expected %0d",
                                       i, row_arg[i], link_rd_next, row_exp_val[i]));
            end
        endcase
        repeat (gap_cycles) @(posedge clk);
    endtask

    task automatic report_test(input int t);
        if (!timed_out) begin
            if (rd_pulses - rd_base != exp_rd[t])
                log_fail($sformatf("inc_freeb_rd_count pulsed %0d times, expected %0d",
                                   rd_pulses - rd_base, exp_rd[t]));
            if (wr_pulses - wr_base != exp_wr[t])
                log_fail($sformatf("inc_freeb_wr_count pulsed %0d times, expected %0d",
                                   wr_pulses - wr_base, exp_wr[t]));
        end
        $display("test %0d (%s): %0d errors", t, test_name[t], test_errs);
    endtask

    initial begin
        rst_n = 1'b0;
        freeb_init = 1'b0;
        free_buf_req = 1'b0;
        rel_buf_valid = 1'b0;
        rel_buf_ptr = '0;
        write_data_valid = 1'b0;
        write_buf_ptr = '0;
        write_sop = 1'b0;
        write_port_id = '0;
        link_rd_ptr = '0;
        errors = 0;
        test_errs = 0;
        rows_done = 0;
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_init_level(1'b1, init_timeout, "freeb_init_done after reset");
        cur_test = 1;
        rd_base = rd_pulses;
        wr_base = wr_pulses;
        for (int i = 0; i < num_rows && !timed_out; i++) begin
            if (row_test[i] != cur_test) begin
                report_test(cur_test);
                cur_test = row_test[i];
                test_errs = 0;
                rd_base = rd_pulses;
                wr_base = wr_pulses;
            end
            apply_row(i);
            rows_done++;
        end
        report_test(cur_test);
        $display("Rows applied %0d of %0d, errors %0d", rows_done, num_rows, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
